/* dv/light_grid_model.svh */
`ifndef LIGHT_GRID_MODEL_SVH
`define LIGHT_GRID_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference grid
////////////////////////////////////////////////////////////////////////////

// Brightness of every modelled light
int grid [model_rows][model_cols];

int unsigned lcg_state = 17;
int error_count = 0;
int check_count = 0;

function automatic int unsigned next_rand(input int unsigned range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return ((lcg_state >> 16) & 32'h7fff) % range;
endfunction

task automatic check_value(input longint actual, input longint expected, input string what);
    check_count++;
    if (actual != expected) begin
        error_count++;
        $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
endtask

// Every run starts from a dark grid
task automatic clear_grid();
    for (int r = 0; r < model_rows; r++) begin
        for (int c = 0; c < model_cols; c++) begin
            grid[r][c] = 0;
        end
    end
endtask

task automatic apply_to_model(input cmd_t cmd);
    for (int r = int'(cmd.start_row); r <= int'(cmd.end_row) && r < model_rows; r++) begin
        for (int c = int'(cmd.start_col); c <= int'(cmd.end_col) && c < model_cols; c++) begin
            case (cmd.op)
                turn_on:  grid[r][c] = (grid[r][c] + 1) % cell_mod;
                toggle:   grid[r][c] = (grid[r][c] + 2) % cell_mod;
                turn_off: grid[r][c] = (grid[r][c] > 0) ? grid[r][c] - 1 : 0;
                default:  grid[r][c] = grid[r][c];
            endcase
        end
    end
endtask

function automatic longint grid_total();
    longint sum;
    sum = 0;
    for (int r = 0; r < model_rows; r++) begin
        for (int c = 0; c < model_cols; c++) begin
            sum += grid[r][c];
        end
    end
    return sum;
endfunction

`endif

/* dv/light_grid_tb.sv */
module light_grid_tb
    import light_grid_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int model_rows = 16;
    localparam int cols_per_ram = 6;
    localparam int ram_count = 2;
    localparam int passes = 2;
    localparam int result_width = 32;
    localparam int bank_width = cols_per_ram * ram_count;
    localparam int model_cols = passes * bank_width;
    localparam int cell_mod = 64;
    localparam int ready_timeout = 200;
    localparam int done_timeout = 1000;

    logic clk = 1'b0;
    logic reset;
    logic instr_valid;
    logic instr_last;
    cmd_t instr_data;
    logic instr_ready;
    logic count_done;
    logic [result_width-1:0] count_value;

    cmd_t cmd_list[$];
    int transfer_count = 0;
    bit aborted = 1'b0;
    longint final_value;

    `include "light_grid_model.svh"

    light_grid_top #(
        .ROWS(model_rows),
        .COLS_PER_RAM(cols_per_ram),
        .RAM_COUNT(ram_count),
        .PASSES(passes),
        .RESULT_WIDTH(result_width)
    ) DUT (
        .clk,
        .reset,
        .instr_valid,
        .instr_last,
        .instr_data,
        .instr_ready,
        .count_done,
        .count_value
    );

    always #4 clk = ~clk;

    // Transfer happens on the edge after this sample
    always @(negedge clk) begin
        if (!reset && instr_valid && instr_ready) begin
            transfer_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic cmd_t make_cmd(input op_e op, input int sr, input int sc,
                                      input int er, input int ec);
        cmd_t c;
        c.op = op;
        c.start_row = pos_t'(sr);
        c.start_col = pos_t'(sc);
        c.end_row = pos_t'(er);
        c.end_col = pos_t'(ec);
        return c;
    endfunction

    function automatic cmd_t random_cmd();
        logic [1:0] op_bits;
        int sr;
        int er;
        int sc;
        int ec;
        op_bits = 2'(next_rand(4));
        sr = next_rand(model_rows);
        er = sr + next_rand(model_rows - sr);
        sc = next_rand(28);
        ec = sc + next_rand(12);
        return make_cmd(op_e'(op_bits), sr, sc, er, ec);
    endfunction

    task automatic apply_reset();
        int waited;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_last = 1'b0;
        // Outputs settle after the first clock edge in reset
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_value(instr_ready, 0, "instr_ready during reset");
            check_value(count_done, 0, "count_done during reset");
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!instr_ready && waited < ready_timeout);
        if (!instr_ready) begin
            $display("Timeout: instr_ready did not rise within %0d cycles after reset",
                     ready_timeout);
            error_count++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_cmd(input cmd_t c, input bit last, input int gap);
        int waited;
        if (aborted) begin
            return;
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        instr_data = c;
        instr_last = last;
        instr_valid = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!instr_ready && waited < ready_timeout);
        if (!instr_ready) begin
            $display("Timeout: command was not accepted within %0d cycles", ready_timeout);
            error_count++;
            aborted = 1'b1;
            instr_valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr_last = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        if (aborted) begin
            return;
        end
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!count_done && waited < done_timeout);
        if (!count_done) begin
            $display("Timeout: count_done did not rise within %0d cycles", done_timeout);
            error_count++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        #1;
    endtask

    // Replays cmd_list once per pass and checks the total against the model
    task automatic run_scenario(input string name, input int max_gap);
        int gap;
        logic [result_width-1:0] held;
        apply_reset();
        if (aborted) begin
            return;
        end
        clear_grid();
        foreach (cmd_list[i]) begin
            apply_to_model(cmd_list[i]);
        end
        transfer_count = 0;
        for (int p = 0; p < passes; p++) begin
            for (int i = 0; i < cmd_list.size(); i++) begin
                gap = (max_gap > 0) ? int'(next_rand(max_gap + 1)) : 0;
                send_cmd(cmd_list[i], i == cmd_list.size() - 1, gap);
            end
        end
        // Spare command stays pending after the final pass and is never taken
        instr_data = make_cmd(reserved, 0, 0, 0, 0);
        instr_last = 1'b0;
        instr_valid = 1'b1;
        wait_done();
        if (aborted) begin
            instr_valid = 1'b0;
            return;
        end
        final_value = count_value;
        check_value(count_value, grid_total(), {name, " total"});
        held = count_value;
        repeat (20) begin
            @(negedge clk);
            check_value(count_done, 1, {name, " count_done held"});
            check_value(count_value, held, {name, " count_value held"});
        end
        check_value(transfer_count, cmd_list.size() * passes, {name, " transfers"});
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_last = 1'b0;
        instr_data = '0;

        apply_reset();

        cmd_list = {};
        cmd_list.push_back(make_cmd(turn_on, 2, 5, 9, 30));
        run_scenario("single turn_on", 0);
        if (!aborted) begin
            check_value(final_value, (9 - 2 + 1) * (model_cols - 5), "turn_on area");
        end

        // Overlap drives some lights to zero and past it
        cmd_list = {};
        cmd_list.push_back(make_cmd(toggle, 1, 3, 6, 15));
        cmd_list.push_back(make_cmd(turn_off, 4, 8, 10, 20));
        cmd_list.push_back(make_cmd(turn_off, 4, 8, 10, 20));
        run_scenario("toggle and turn_off", 2);

        // Whole grid lit once, then reserved and out of range commands on top
        cmd_list = {};
        cmd_list.push_back(make_cmd(turn_on, 0, 0, 15, 23));
        cmd_list.push_back(make_cmd(turn_on, 0, 24, 15, 40));
        cmd_list.push_back(make_cmd(reserved, 0, 0, 15, 23));
        cmd_list.push_back(make_cmd(toggle, 3, 30, 5, 4000));
        run_scenario("ignored columns and reserved", 1);
        if (!aborted) begin
            check_value(final_value, model_rows * model_cols,
                        "sum unchanged by ignored commands");
        end

        cmd_list = {};
        repeat (12) begin
            cmd_list.push_back(random_cmd());
        end
        run_scenario("random list", 3);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+dv
src/light_grid_pkg.sv
src/light_col_ram.sv
src/light_col_bank.sv
src/row_sweep_timer.sv
src/light_grid_ctrl.sv
src/light_grid_top.sv
dv/light_grid_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the light grid testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module light_grid_tb -f filelist.f

./obj_dir/Vlight_grid_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

/* src/light_col_bank.sv */
module light_col_bank
    import light_grid_pkg::*;
#(
    parameter int COLS_PER_RAM = 6,
    parameter int ROWS = 16,
    parameter int RESULT_WIDTH = 32,
    parameter int BANK_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  sweep_ctl_t              ctl,
    input  cmd_t                    cmd,
    input  pos_t                    pass_offset,
    input  logic [RESULT_WIDTH-1:0] acc_in,
    output logic [RESULT_WIDTH-1:0] acc_out
);

    localparam int word_bits = cell_bits * COLS_PER_RAM;
    localparam int addr_bits = $clog2(ROWS);
    localparam int col_acc_bits = cell_bits + $clog2(ROWS + 1);

    logic [word_bits-1:0] rd_word;
    logic [word_bits-1:0] wr_word;
    logic [COLS_PER_RAM-1:0][col_acc_bits-1:0] col_acc;
    logic [RESULT_WIDTH-1:0] bank_sum;

    light_col_ram #(
        .DEPTH(ROWS),
        .WIDTH(word_bits)
    ) u_ram (
        .clk,
        .rd_addr(ctl.rd_row[addr_bits-1:0]),
        .rd_data(rd_word),
        .wr_en(ctl.wr_en),
        .wr_addr(ctl.wr_row[addr_bits-1:0]),
        .wr_data(wr_word)
    );

    for (genvar j = 0; j < COLS_PER_RAM; j++) begin : g_col
        localparam int col_index = BANK_INDEX * COLS_PER_RAM + j;

        cell_t rd_cell;
        cell_t next_cell;
        cell_t wr_cell;
        logic [pos_bits:0] abs_col;
        logic hit;

        assign rd_cell = rd_word[j*cell_bits +: cell_bits];
        assign abs_col = {1'b0, pass_offset} + (pos_bits + 1)'(col_index);
        assign hit = (abs_col >= {1'b0, cmd.start_col}) && (abs_col <= {1'b0, cmd.end_col});

        always_comb begin
            next_cell = rd_cell;
            if (hit) begin
                unique case (cmd.op)
                    turn_on:  next_cell = rd_cell + cell_t'(1);
                    toggle:   next_cell = rd_cell + cell_t'(2);
                    turn_off: next_cell = (rd_cell != '0) ? rd_cell - cell_t'(1) : rd_cell;
                    reserved: next_cell = rd_cell;
                    default:  next_cell = rd_cell;
                endcase
            end
        end

        // Third pipeline stage of the read-modify-write
        always_ff @(posedge clk) begin
            wr_cell <= next_cell;
        end

        assign wr_word[j*cell_bits +: cell_bits] = ctl.update_active ? wr_cell : '0;

        always_ff @(posedge clk) begin
            if (reset) begin
                col_acc[j] <= '0;
            end else if (ctl.acc_clear) begin
                col_acc[j] <= '0;
            end else if (ctl.sum_en) begin
                col_acc[j] <= col_acc[j] + col_acc_bits'(rd_cell);
            end
        end
    end

    always_comb begin
        bank_sum = '0;
        for (int k = 0; k < COLS_PER_RAM; k++) begin
            bank_sum = bank_sum + RESULT_WIDTH'(col_acc[k]);
        end
    end

    // One stage of the bank-to-bank cascade
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_out <= '0;
        end else if (ctl.acc_clear) begin
            acc_out <= '0;
        end else if (ctl.cascade_en) begin
            acc_out <= acc_in + bank_sum;
        end
    end

endmodule

/* src/light_col_ram.sv */
module light_col_ram #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 36
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Grid starts dark
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* src/light_grid_ctrl.sv */
module light_grid_ctrl
    import light_grid_pkg::*;
#(
    parameter int COLS_PER_RAM = 6,
    parameter int RAM_COUNT = 2,
    parameter int PASSES = 2,
    parameter int RESULT_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic                    instr_last,
    input  cmd_t                    instr_data,
    output logic                    instr_ready,
    output logic                    sweep_start,
    output sweep_mode_e             sweep_mode,
    output pos_t                    sweep_first_row,
    output pos_t                    sweep_last_row,
    input  logic                    sweep_done,
    input  logic [RESULT_WIDTH-1:0] total_in,
    output cmd_t                    cmd,
    output pos_t                    pass_offset,
    output logic                    count_done,
    output logic [RESULT_WIDTH-1:0] count_value
);

    localparam int pass_bits = $clog2(PASSES + 1);
    localparam int bank_width = COLS_PER_RAM * RAM_COUNT;

    ctrl_state_e state, next_state;
    cmd_t cmd_q;
    logic last_q;
    logic [pass_bits-1:0] pass_cnt;
    logic passes_done;

    // Pass count already advanced in capture_sum
    assign passes_done = (pass_cnt == pass_bits'(PASSES));

    always_comb begin
        next_state = state;
        unique case (state)
            st_wait_reset:  next_state = st_accept;
            st_accept: begin
                if (instr_valid) begin
                    next_state = st_capture;
                end
            end
            st_capture:     next_state = st_update;
            st_update: begin
                if (sweep_done) begin
                    next_state = last_q ? st_start_sum : st_accept;
                end
            end
            st_start_sum:   next_state = st_row_sweep;
            st_row_sweep: begin
                if (sweep_done) begin
                    next_state = st_cascade;
                end
            end
            st_cascade: begin
                if (sweep_done) begin
                    next_state = st_capture_sum;
                end
            end
            st_capture_sum: next_state = st_start_clear;
            st_start_clear: next_state = st_clear;
            st_clear: begin
                if (sweep_done) begin
                    next_state = passes_done ? st_finished : st_accept;
                end
            end
            st_finished:    next_state = st_finished;
            default:        next_state = st_wait_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_wait_reset;
        end else begin
            state <= next_state;
        end
    end

    // One command in flight, so the capture register is free in accept
    always_ff @(posedge clk) begin
        if (instr_ready && instr_valid) begin
            cmd_q <= instr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q <= 1'b0;
            pass_cnt <= '0;
            pass_offset <= '0;
            count_value <= '0;
        end else begin
            if (instr_ready && instr_valid) begin
                last_q <= instr_last;
            end
            if (state == st_capture_sum) begin
                count_value <= count_value + total_in;
                pass_cnt <= pass_cnt + 1'b1;
                pass_offset <= pass_offset + pos_bits'(bank_width);
            end
        end
    end

    assign instr_ready = (state == st_accept);
    assign count_done = (state == st_finished);
    assign cmd = cmd_q;

    // Sweep requests
    assign sweep_start = (state == st_capture) || (state == st_start_sum)
                      || (state == st_start_clear);
    assign sweep_first_row = cmd_q.start_row;
    assign sweep_last_row = cmd_q.end_row;

    always_comb begin
        unique case (state)
            st_start_sum:   sweep_mode = mode_sum;
            st_start_clear: sweep_mode = mode_clear;
            default:        sweep_mode = mode_update;
        endcase
    end

endmodule

/* src/light_grid_pkg.sv */
package light_grid_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and pipeline depth
    ////////////////////////////////////////////////////////////////////////////

    localparam int pos_bits = 12;
    localparam int cell_bits = 6;

    // Read to write distance is update_latency-1 cycles
    localparam int update_latency = 3;

    typedef logic [pos_bits-1:0] pos_t;
    typedef logic [cell_bits-1:0] cell_t;

    ////////////////////////////////////////////////////////////////////////////
    // Command stream
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        turn_off = 2'b00,
        toggle   = 2'b01,
        reserved = 2'b10,
        turn_on  = 2'b11
    } op_e;

    typedef struct packed {
        op_e  op;
        pos_t start_row;
        pos_t start_col;
        pos_t end_row;
        pos_t end_col;
    } cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Controller and sweep timer
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        st_wait_reset,
        st_accept,
        st_capture,
        st_update,
        st_start_sum,
        st_row_sweep,
        st_cascade,
        st_capture_sum,
        st_start_clear,
        st_clear,
        st_finished
    } ctrl_state_e;

    typedef enum logic [1:0] {
        mode_update,
        mode_sum,
        mode_clear
    } sweep_mode_e;

    // Broadcast from the timer to every bank
    typedef struct packed {
        pos_t rd_row;
        pos_t wr_row;
        logic wr_en;
        logic update_active;
        logic sum_en;
        logic cascade_en;
        logic acc_clear;
    } sweep_ctl_t;

endpackage

/* src/light_grid_top.sv */
module light_grid_top
    import light_grid_pkg::*;
#(
    parameter int ROWS = 16,
    parameter int COLS_PER_RAM = 6,
    parameter int RAM_COUNT = 2,
    parameter int PASSES = 2,
    parameter int RESULT_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic                    instr_last,
    input  cmd_t                    instr_data,
    output logic                    instr_ready,
    output logic                    count_done,
    output logic [RESULT_WIDTH-1:0] count_value
);

    logic sweep_start;
    sweep_mode_e sweep_mode;
    pos_t sweep_first_row;
    pos_t sweep_last_row;
    logic sweep_done;
    sweep_ctl_t ctl;
    cmd_t cmd;
    pos_t pass_offset;

    // Entry 0 feeds bank 0, the last entry is the grid total
    logic [RAM_COUNT:0][RESULT_WIDTH-1:0] acc_chain;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    light_grid_ctrl #(
        .COLS_PER_RAM(COLS_PER_RAM),
        .RAM_COUNT(RAM_COUNT),
        .PASSES(PASSES),
        .RESULT_WIDTH(RESULT_WIDTH)
    ) u_ctrl (
        .clk,
        .reset,
        .instr_valid,
        .instr_last,
        .instr_data,
        .instr_ready,
        .sweep_start,
        .sweep_mode,
        .sweep_first_row,
        .sweep_last_row,
        .sweep_done,
        .total_in(acc_chain[RAM_COUNT]),
        .cmd,
        .pass_offset,
        .count_done,
        .count_value
    );

    row_sweep_timer #(
        .ROWS(ROWS),
        .RAM_COUNT(RAM_COUNT)
    ) u_timer (
        .clk,
        .reset,
        .start(sweep_start),
        .mode(sweep_mode),
        .first_row(sweep_first_row),
        .last_row(sweep_last_row),
        .done(sweep_done),
        .ctl
    );

    ////////////////////////////////////////////////////////////////////////////
    // Column banks
    ////////////////////////////////////////////////////////////////////////////

    assign acc_chain[0] = '0;

    for (genvar i = 0; i < RAM_COUNT; i++) begin : g_bank
        light_col_bank #(
            .COLS_PER_RAM(COLS_PER_RAM),
            .ROWS(ROWS),
            .RESULT_WIDTH(RESULT_WIDTH),
            .BANK_INDEX(i)
        ) u_bank (
            .clk,
            .reset,
            .ctl,
            .cmd,
            .pass_offset,
            .acc_in(acc_chain[i]),
            .acc_out(acc_chain[i+1])
        );
    end

endmodule

/* src/row_sweep_timer.sv */
module row_sweep_timer
    import light_grid_pkg::*;
#(
    parameter int ROWS = 16,
    parameter int RAM_COUNT = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  sweep_mode_e mode,
    input  pos_t        first_row,
    input  pos_t        last_row,
    output logic        done,
    output sweep_ctl_t  ctl
);

    localparam int wr_tap = update_latency - 1;
    localparam int cnt_bits = $clog2(ROWS + update_latency + RAM_COUNT + 1);

    sweep_mode_e mode_q;
    pos_t rd_ptr;
    pos_t end_ptr;
    logic rd_on;
    pos_t [wr_tap:1] row_sr;
    logic [wr_tap:1] we_sr;
    logic sum_on;
    logic cascade_on;
    logic sum_valid;
    logic acc_clear_q;
    logic [cnt_bits-1:0] cnt;

    // Row pointers follow the read pointer down the pipeline
    always_ff @(posedge clk) begin
        row_sr[1] <= rd_ptr;
        for (int k = 2; k <= wr_tap; k++) begin
            row_sr[k] <= row_sr[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q <= mode_update;
            rd_ptr <= '0;
            end_ptr <= '0;
            rd_on <= 1'b0;
            we_sr <= '0;
            sum_on <= 1'b0;
            cascade_on <= 1'b0;
            sum_valid <= 1'b0;
            acc_clear_q <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            we_sr[1] <= rd_on && (mode_q == mode_update);
            for (int k = 2; k <= wr_tap; k++) begin
                we_sr[k] <= we_sr[k-1];
            end
            sum_valid <= rd_on && (mode_q == mode_sum);
            acc_clear_q <= done && (mode_q == mode_sum) && !cascade_on && !sum_on;

            if (start) begin
                mode_q <= mode;
                cnt <= '0;
                rd_on <= 1'b1;
                rd_ptr <= (mode == mode_update) ? first_row : '0;
                end_ptr <= (mode == mode_update) ? last_row : pos_bits'(ROWS - 1);
                sum_on <= (mode == mode_sum);
            end else begin
                if (rd_on) begin
                    if (rd_ptr >= end_ptr) begin
                        rd_on <= 1'b0;
                        done <= (mode_q == mode_clear);
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end

                // Final write of a command sweep
                if ((mode_q == mode_update) && we_sr[wr_tap] && (row_sr[wr_tap] >= end_ptr)) begin
                    done <= 1'b1;
                end

                if (sum_on) begin
                    if (cnt == cnt_bits'(ROWS + update_latency - 1)) begin
                        sum_on <= 1'b0;
                        cascade_on <= 1'b1;
                        cnt <= '0;
                        done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end else if (cascade_on) begin
                    if (cnt == cnt_bits'(RAM_COUNT)) begin
                        cascade_on <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Clear writes straight from the pointer, updates from the delay line
    assign ctl.rd_row = rd_ptr;
    assign ctl.wr_row = (mode_q == mode_clear) ? rd_ptr : row_sr[wr_tap];
    assign ctl.wr_en = (mode_q == mode_clear) ? rd_on : we_sr[wr_tap];
    assign ctl.update_active = (mode_q == mode_update);
    assign ctl.sum_en = sum_valid;
    assign ctl.cascade_en = cascade_on;
    assign ctl.acc_clear = acc_clear_q;

endmodule
